//--- Bender.yml
package:
  name: dma_controller

sources:
  - verilog/dma_pkg.sv
  - verilog/dma_regfile.sv
  - verilog/dma_arbiter.sv
  - verilog/dma_transfer_engine.sv
  - verilog/dma_top.sv
  - target: test
    files:
      - verif/dma_properties.sv
      - verif/dma_tb.sv

//--- sources.f
verilog/dma_pkg.sv
verilog/dma_regfile.sv
verilog/dma_arbiter.sv
verilog/dma_transfer_engine.sv
verilog/dma_top.sv
verif/dma_properties.sv
verif/dma_tb.sv

//--- verif/dma_golden.txt
# fields in hex: P ch src dest count mode | W addr data | R addr expected | Q dreq_mask
# D wait until idle | E dest data eop | Z no pending writes | T test name
T readback
P 3 a5 3c 07 02
R 0c a5
R 0d 3c
R 0e 07
R 0f 02
W 10 02
R 10 02
T single_up
W 10 01
P 0 10 80 02 00
Q 1
D
E 80 4a 0
E 81 4b 0
E 82 48 1
Z
T block_down
P 1 40 90 03 03
Q 2
D
Q 0
E 90 1a 0
E 91 65 0
E 92 64 0
E 93 67 1
Z
T fixed_prio
P 1 20 a0 01 00
P 2 30 b0 01 00
Q 6
D
Q 0
E a0 7a 0
E a1 7b 1
E b0 6a 0
E b1 6b 1
Z
T rotate_prio
W 10 03
P 0 50 c0 01 00
P 1 60 d0 01 00
Q 3
D
E c0 0a 0
E d0 3a 0
E c1 0b 1
E d1 3b 1
Z
T tc_disarm
Q 1
D
Z
W 02 00
D
E c2 08 1
Z
Q 0

//--- verif/dma_properties.sv
`timescale 1ns/1ps

module dma_properties (
  input logic                       clk,
  input logic                       rst_n,
  input dma_pkg::eng_state_e        state,
  input logic                       hlda,
  input logic [dma_pkg::NUM_CH-1:0] dack,
  input logic                       mem_rd,
  input logic                       mem_wr,
  input logic                       eop
);
  import dma_pkg::*;

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr))
    else $error("mem_rd and mem_wr high in the same cycle");

  a_dack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(dack))
    else $error("dack has more than one channel acknowledged");

  // bus stays granted from load through step
  a_busy_hlda: assert property (@(posedge clk) disable iff (!rst_n)
    (state != ST_IDLE && state != ST_HOLD) |-> hlda)
    else $error("engine moving data without hold acknowledge");

  a_strobe_hlda: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_rd || mem_wr) |-> hlda)
    else $error("memory strobe without hold acknowledge");

  a_eop_wr: assert property (@(posedge clk) disable iff (!rst_n) eop |-> mem_wr)
    else $error("eop outside a memory write");

endmodule

bind dma_transfer_engine dma_properties u_properties (
  .clk    (clk),
  .rst_n  (rst_n),
  .state  (state),
  .hlda   (hlda),
  .dack   (dack),
  .mem_rd (mem_rd),
  .mem_wr (mem_wr),
  .eop    (eop)
);

//--- verif/dma_tb.sv
`timescale 1ns/1ps

module dma_tb;
  import dma_pkg::*;

  localparam int CYCLES_PER_LINE = 200;
  localparam int IDLE_CYCLES     = 8;  // hrq low this long means nothing is left to serve

  typedef struct packed {
    logic              eop;
    logic [NUM_CH-1:0] dack;
    addr_t             dest;
    data_t             data;
  } bus_wr_t;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  cpu_cs;
  logic                  cpu_wr;
  logic                  cpu_rd;
  logic [REG_ADDR_W-1:0] cpu_addr;
  data_t                 cpu_wdata;
  data_t                 cpu_rdata;
  logic [NUM_CH-1:0]     dreq;
  logic [NUM_CH-1:0]     dack;
  logic                  hrq;
  logic                  hlda = 1'b0;
  logic                  mem_rd;
  logic                  mem_wr;
  addr_t                 bus_addr;
  data_t                 bus_wdata;
  data_t                 bus_rdata = '0;
  logic                  eop;

  bus_wr_t wr_q[$];     // observed bus writes in arrival order
  string   script[$];
  addr_t   next_dest [NUM_CH];  // destination each channel writes next
  string   test_name = "none";
  integer  seed = 91773;
  int      hold_cyc;
  int      hold_dly;
  int      n_checks;
  int      n_errors;
  int      timeout_cycles;

  dma_top u_dma_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_cs    (cpu_cs),
    .cpu_wr    (cpu_wr),
    .cpu_rd    (cpu_rd),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_rdata (cpu_rdata),
    .dreq      (dreq),
    .dack      (dack),
    .hrq       (hrq),
    .hlda      (hlda),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .eop       (eop)
  );

  always #2 clk = ~clk;

  // bus owner model granting hold after 1 to 4 cycles
  always @(posedge clk)
  begin
    if (!rst_n || !hrq)
    begin
      hlda     <= 1'b0;
      hold_cyc <= 0;
    end
    else
    begin
      if (hold_cyc == 0)
        hold_dly <= 1 + ($unsigned($random(seed)) % 4);
      else if (hold_cyc >= hold_dly)
        hlda <= 1'b1;
      hold_cyc <= hold_cyc + 1;
    end
    if (mem_rd)
      bus_rdata <= bus_addr ^ 8'h5a;  // memory content rule
  end

  always @(posedge clk)
  begin
    if (rst_n && mem_wr)
      wr_q.push_back(bus_wr_t'({eop, dack, bus_addr, bus_wdata}));
  end

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    n_checks++;
    if (expected !== actual)
    begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      n_errors++;
    end
  endtask

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input data_t data);
    if (addr < REG_CMD && addr[REG_OFS_W-1:0] == REG_DEST)
      next_dest[addr[REG_OFS_W +: CH_W]] = data;
    @(posedge clk);
    cpu_cs    <= 1'b1;
    cpu_wr    <= 1'b1;
    cpu_addr  <= addr;
    cpu_wdata <= data;
    @(posedge clk);
    cpu_cs <= 1'b0;
    cpu_wr <= 1'b0;
  endtask

  task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, input data_t expected);
    @(posedge clk);
    cpu_cs   <= 1'b1;
    cpu_rd   <= 1'b1;
    cpu_addr <= addr;
    @(posedge clk);
    cpu_cs <= 1'b0;
    cpu_rd <= 1'b0;
    @(negedge clk);  // rdata registered on the edge above
    check($sformatf("read reg %0h", addr), expected, cpu_rdata);
  endtask

  // count goes last because it arms the channel
  task automatic program_channel(input ch_t ch, input addr_t src, input addr_t dest,
                                 input data_t count, input data_t mode);
    reg_write({1'b0, ch, REG_SRC}, src);
    reg_write({1'b0, ch, REG_DEST}, dest);
    reg_write({1'b0, ch, REG_MODE}, mode);
    reg_write({1'b0, ch, REG_COUNT}, count);
  endtask

  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < IDLE_CYCLES)
    begin
      @(negedge clk);
      quiet = hrq ? 0 : quiet + 1;
    end
  endtask

  task automatic expect_write(input addr_t dest, input data_t data, input logic last);
    bus_wr_t got;
    int      exp_ch;
    exp_ch = -1;
    for (int c = NUM_CH - 1; c >= 0; c--)
    begin
      if (next_dest[c] === dest)
        exp_ch = c;  // channel whose destination pointer is here
    end
    if (wr_q.size() == 0)
    begin
      $display("ERROR %s: no bus write was seen for destination %0h", test_name, dest);
      n_errors++;
    end
    else
    begin
      got = wr_q.pop_front();
      check("write dest", dest, got.dest);
      check("write data", data, got.data);
      check("write eop", last, got.eop);
      if (exp_ch < 0)
      begin
        $display("ERROR %s: no programmed channel writes to destination %0h",
                 test_name, dest);
        n_errors++;
      end
      else
        check("write dack", 1 << exp_ch, got.dack);
    end
    if (exp_ch >= 0)
      next_dest[exp_ch] = dest + 8'd1;
  endtask

  task automatic run_command(input string line);
    logic [7:0] op;
    logic [7:0] f1;
    logic [7:0] f2;
    logic [7:0] f3;
    logic [7:0] f4;
    logic [7:0] f5;
    int         n_fields;
    n_fields = $sscanf(line, "%c %h %h %h %h %h", op, f1, f2, f3, f4, f5);
    case (op)
      "T": test_name = line.substr(2, line.len() - 2);  // drop the newline
      "P": program_channel(f1[CH_W-1:0], f2, f3, f4, f5);
      "W": reg_write(f1[REG_ADDR_W-1:0], f2);
      "R": reg_read(f1[REG_ADDR_W-1:0], f2);
      "Q":
      begin
        @(posedge clk);
        dreq <= f1[NUM_CH-1:0];
      end
      "D": wait_idle();
      "E": expect_write(f1, f2, f3[0]);
      "Z":
      begin
        check("pending writes", 0, wr_q.size());
        wr_q.delete();
      end
      default:
      begin
        $display("ERROR golden line not understood (%0d fields): %s", n_fields, line);
        n_errors++;
      end
    endcase
  endtask

  initial
  begin
    int    fd;
    string line;
    rst_n     = 1'b0;
    cpu_cs    = 1'b0;
    cpu_wr    = 1'b0;
    cpu_rd    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    dreq      = '0;
    fd = $fopen("verif/dma_golden.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR the golden file verif/dma_golden.txt could not be opened");
      n_errors++;
    end
    else
    begin
      while ($fgets(line, fd))
        script.push_back(line);
      $fclose(fd);
    end
    timeout_cycles = CYCLES_PER_LINE * (script.size() + 1);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    foreach (script[i])
    begin
      if (script[i].len() > 1 && script[i].getc(0) != "#")
        run_command(script[i]);
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("ERROR watchdog expired after %0d cycles, the DUT stopped making progress",
             timeout_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verilog/dma_arbiter.sv
`timescale 1ns/1ps

module dma_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [dma_pkg::NUM_CH-1:0] dreq,
  input  logic [dma_pkg::NUM_CH-1:0] armed,
  input  dma_pkg::prio_mode_e        prio_mode,
  input  logic                       start,
  input  dma_pkg::ch_t               start_ch,
  output dma_pkg::grant_t            grant
);
  import dma_pkg::*;

  logic [NUM_CH-1:0] req;
  ch_t               last_q;  // lowest priority in rotating mode
  ch_t               base;
  ch_t               cand;

  assign req = dreq & armed;

  // fixed mode behaves as if channel 3 had been served last
  assign base = (prio_mode == PRIO_ROTATE) ? last_q : ch_t'(NUM_CH - 1);

  // search runs from lowest to highest priority, so the last hit wins
  always_comb
  begin
    grant = '0;
    cand  = base;
    for (int i = NUM_CH - 1; i >= 0; i--)
    begin
      cand = base + ch_t'(i + 1);
      if (req[cand])
      begin
        grant.valid   = 1'b1;
        grant.channel = cand;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      last_q <= ch_t'(NUM_CH - 1);  // channel 0 goes first
    else if (start && prio_mode == PRIO_ROTATE)
      last_q <= start_ch;
  end

endmodule

//--- verilog/dma_pkg.sv
package dma_pkg;

  localparam int NUM_CH     = 4;
  localparam int ADDR_W     = 8;
  localparam int DATA_W     = 8;
  localparam int CH_W       = 2;
  localparam int REG_ADDR_W = 5;
  localparam int REG_OFS_W  = 2;  // register field inside a channel

  // channel register offsets, cpu_addr = channel * 4 + offset
  localparam logic [REG_OFS_W-1:0] REG_SRC   = 2'd0;
  localparam logic [REG_OFS_W-1:0] REG_DEST  = 2'd1;
  localparam logic [REG_OFS_W-1:0] REG_COUNT = 2'd2;
  localparam logic [REG_OFS_W-1:0] REG_MODE  = 2'd3;

  localparam logic [REG_ADDR_W-1:0] REG_CMD = 5'd16;

  // bit positions in the mode and command registers
  localparam int MODE_BLOCK_BIT = 0;
  localparam int MODE_DESC_BIT  = 1;
  localparam int CMD_EN_BIT     = 0;
  localparam int CMD_ROT_BIT    = 1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CH_W-1:0]   ch_t;

  typedef enum logic {
    XFER_SINGLE,
    XFER_BLOCK
  } xfer_mode_e;

  typedef enum logic {
    PRIO_FIXED,
    PRIO_ROTATE
  } prio_mode_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HOLD,
    ST_LOAD,
    ST_READ,
    ST_LATCH,
    ST_WRITE,
    ST_STEP
  } eng_state_e;

  typedef struct packed {
    addr_t      src;
    addr_t      dest;
    data_t      count;       // bytes left minus one
    logic       descending;  // source steps down
    xfer_mode_e mode;
  } chan_ctx_t;

  typedef struct packed {
    logic valid;
    ch_t  channel;
  } grant_t;

  typedef struct packed {
    logic      valid;
    ch_t       channel;
    chan_ctx_t ctx;
    logic      done;  // terminal count reached
  } ctx_wb_t;

endpackage

//--- verilog/dma_regfile.sv
`timescale 1ns/1ps

module dma_regfile (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cpu_cs,
  input  logic                           cpu_wr,
  input  logic                           cpu_rd,
  input  logic [dma_pkg::REG_ADDR_W-1:0] cpu_addr,
  input  dma_pkg::data_t                 cpu_wdata,
  output dma_pkg::data_t                 cpu_rdata,
  input  dma_pkg::ch_t                   ctx_sel,
  output dma_pkg::chan_ctx_t             ctx,
  input  dma_pkg::ctx_wb_t               wb,
  output logic [dma_pkg::NUM_CH-1:0]     armed,
  output dma_pkg::prio_mode_e            prio_mode,
  output logic                           enable
);
  import dma_pkg::*;

  chan_ctx_t            ch_ctx [NUM_CH];
  ch_t                  reg_ch;
  logic [REG_OFS_W-1:0] reg_ofs;
  logic                 chan_hit;
  logic                 cmd_hit;
  logic                 wr_en;
  data_t                rd_val;

  assign reg_ch   = cpu_addr[REG_OFS_W +: CH_W];
  assign reg_ofs  = cpu_addr[REG_OFS_W-1:0];
  assign chan_hit = (cpu_addr < REG_CMD);  // indices 0..15
  assign cmd_hit  = (cpu_addr == REG_CMD);
  assign wr_en    = cpu_cs && cpu_wr;

  assign ctx = ch_ctx[ctx_sel];  // engine context readout

  always_ff @(posedge clk)
  begin
    if (wb.valid)
      ch_ctx[wb.channel] <= wb.ctx;
    else if (wr_en && chan_hit)
    begin
      case (reg_ofs)
        REG_SRC:   ch_ctx[reg_ch].src   <= cpu_wdata;
        REG_DEST:  ch_ctx[reg_ch].dest  <= cpu_wdata;
        REG_COUNT: ch_ctx[reg_ch].count <= cpu_wdata;
        REG_MODE:
        begin
          ch_ctx[reg_ch].mode       <= xfer_mode_e'(cpu_wdata[MODE_BLOCK_BIT]);
          ch_ctx[reg_ch].descending <= cpu_wdata[MODE_DESC_BIT];
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      armed     <= '0;
      enable    <= 1'b0;
      prio_mode <= PRIO_FIXED;
    end
    else
    begin
      if (wb.valid && wb.done)
        armed[wb.channel] <= 1'b0;  // terminal count
      if (wr_en && chan_hit && reg_ofs == REG_COUNT)
        armed[reg_ch] <= 1'b1;
      if (wr_en && cmd_hit)
      begin
        enable    <= cpu_wdata[CMD_EN_BIT];
        prio_mode <= cpu_wdata[CMD_ROT_BIT] ? PRIO_ROTATE : PRIO_FIXED;
      end
    end
  end

  always_comb
  begin
    rd_val = '0;
    if (cmd_hit)
    begin
      rd_val[CMD_EN_BIT]  = enable;
      rd_val[CMD_ROT_BIT] = (prio_mode == PRIO_ROTATE);
    end
    else if (chan_hit)
    begin
      case (reg_ofs)
        REG_SRC:   rd_val = ch_ctx[reg_ch].src;
        REG_DEST:  rd_val = ch_ctx[reg_ch].dest;
        REG_COUNT: rd_val = ch_ctx[reg_ch].count;
        REG_MODE:
        begin
          rd_val[MODE_BLOCK_BIT] = (ch_ctx[reg_ch].mode == XFER_BLOCK);
          rd_val[MODE_DESC_BIT]  = ch_ctx[reg_ch].descending;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cpu_rdata <= '0;
    else if (cpu_cs && cpu_rd)
      cpu_rdata <= rd_val;  // valid the cycle after the strobe
  end

endmodule

//--- verilog/dma_top.sv
`timescale 1ns/1ps

module dma_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cpu_cs,
  input  logic                           cpu_wr,
  input  logic                           cpu_rd,
  input  logic [dma_pkg::REG_ADDR_W-1:0] cpu_addr,
  input  dma_pkg::data_t                 cpu_wdata,
  output dma_pkg::data_t                 cpu_rdata,
  input  logic [dma_pkg::NUM_CH-1:0]     dreq,
  output logic [dma_pkg::NUM_CH-1:0]     dack,
  output logic                           hrq,
  input  logic                           hlda,
  output logic                           mem_rd,
  output logic                           mem_wr,
  output dma_pkg::addr_t                 bus_addr,
  output dma_pkg::data_t                 bus_wdata,
  input  dma_pkg::data_t                 bus_rdata,
  output logic                           eop
);
  import dma_pkg::*;

  logic [NUM_CH-1:0] armed;
  prio_mode_e        prio_mode;
  logic              enable;
  grant_t            grant;
  logic              start;
  ch_t               start_ch;
  ch_t               ctx_sel;
  chan_ctx_t         ctx;
  ctx_wb_t           wb;

  dma_regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_cs    (cpu_cs),
    .cpu_wr    (cpu_wr & ~hrq),  // no programming while the bus is requested
    .cpu_rd    (cpu_rd),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_rdata (cpu_rdata),
    .ctx_sel   (ctx_sel),
    .ctx       (ctx),
    .wb        (wb),
    .armed     (armed),
    .prio_mode (prio_mode),
    .enable    (enable)
  );

  dma_arbiter u_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .dreq      (dreq),
    .armed     (armed),
    .prio_mode (prio_mode),
    .start     (start),
    .start_ch  (start_ch),
    .grant     (grant)
  );

  dma_transfer_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .grant     (grant),
    .start     (start),
    .start_ch  (start_ch),
    .ctx_sel   (ctx_sel),
    .ctx       (ctx),
    .wb        (wb),
    .hrq       (hrq),
    .hlda      (hlda),
    .dack      (dack),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .eop       (eop),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata)
  );

endmodule

//--- verilog/dma_transfer_engine.sv
`timescale 1ns/1ps

module dma_transfer_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable,
  input  dma_pkg::grant_t            grant,
  output logic                       start,
  output dma_pkg::ch_t               start_ch,
  output dma_pkg::ch_t               ctx_sel,
  input  dma_pkg::chan_ctx_t         ctx,
  output dma_pkg::ctx_wb_t           wb,
  output logic                       hrq,
  input  logic                       hlda,
  output logic [dma_pkg::NUM_CH-1:0] dack,
  output logic                       mem_rd,
  output logic                       mem_wr,
  output logic                       eop,
  output dma_pkg::addr_t             bus_addr,
  output dma_pkg::data_t             bus_wdata,
  input  dma_pkg::data_t             bus_rdata
);
  import dma_pkg::*;

  eng_state_e state;
  eng_state_e state_nxt;
  ch_t        ch_q;      // active channel
  chan_ctx_t  work;      // working copy of the channel context
  chan_ctx_t  step_ctx;
  data_t      data_q;    // byte in flight
  logic       last_byte;
  logic       busy;

  assign last_byte = (work.count == '0);
  assign busy      = (state != ST_IDLE) && (state != ST_HOLD);

  always_comb
  begin
    step_ctx      = work;
    step_ctx.dest = work.dest + 8'd1;
    step_ctx.src  = work.descending ? work.src - 8'd1 : work.src + 8'd1;
    if (!last_byte)
      step_ctx.count = work.count - 8'd1;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (enable && grant.valid) state_nxt = ST_HOLD;
      ST_HOLD:  if (hlda) state_nxt = ST_LOAD;  // wait for the bus
      ST_LOAD:  state_nxt = ST_READ;
      ST_READ:  state_nxt = ST_LATCH;
      ST_LATCH: state_nxt = ST_WRITE;
      ST_WRITE: state_nxt = ST_STEP;
      ST_STEP:
      begin
        if (work.mode == XFER_BLOCK && !last_byte)
          state_nxt = ST_READ;
        else
          state_nxt = ST_IDLE;
      end
      default:  state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
      ch_q  <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (start)
        ch_q <= grant.channel;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_LOAD)
      work <= ctx;
    else if (state == ST_STEP)
      work <= step_ctx;
    if (state == ST_LATCH)
      data_q <= bus_rdata;  // read data arrives the cycle after mem_rd
  end

  assign start    = (state == ST_IDLE) && enable && grant.valid;
  assign start_ch = grant.channel;
  assign ctx_sel  = ch_q;

  // hrq rises on entry to hold and falls on the edge after step
  assign hrq = (state != ST_IDLE);

  always_comb
  begin
    dack = '0;
    if (busy)
      dack[ch_q] = 1'b1;
  end

  assign mem_rd    = (state == ST_READ);
  assign mem_wr    = (state == ST_WRITE);
  assign eop       = mem_wr && last_byte;
  assign bus_addr  = (state == ST_WRITE) ? work.dest : work.src;
  assign bus_wdata = data_q;

  // single mode returns after every byte, block mode only at terminal count
  assign wb.valid   = (state == ST_STEP) && (state_nxt == ST_IDLE);
  assign wb.channel = ch_q;
  assign wb.ctx     = step_ctx;
  assign wb.done    = last_byte;

endmodule
